// File: Makefile
# Verilator flow for the PET bus testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_pet_bus
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: address_decoder.sv
// PET memory map decode, combinational from the CPU address
// Only the $FFF0 expansion register holds state, written on the data strobe
// Register bits 4 to 6 are not stored
// The I/O page is never remapped into an expansion bank
`timescale 1ns/1ps

module address_decoder (
    input  logic                                   sys_clock_i,
    input  logic                                   sys_reset_ni,
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                                   cpu_we_i,
    input  logic                                   data_strobe_i,
    output pet_bus_pkg::decode_t                   decode_o
);

    // Expansion control register
    logic exp_wp_low_q;
    logic exp_wp_high_q;
    logic exp_sel_low_q;
    logic exp_sel_high_q;
    logic exp_enable_q;
    logic exp_write;

    logic in_vram;
    logic in_rom;
    logic in_io;
    logic in_low_bank;
    logic in_high_bank;
    logic [11:0] io_window;     // Address bits 15:4

    assign exp_write = data_strobe_i && cpu_we_i
                       && (cpu_addr_i == pet_bus_pkg::EXP_CTRL_ADDR);

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            exp_wp_low_q   <= 1'b0;
            exp_wp_high_q  <= 1'b0;
            exp_sel_low_q  <= 1'b0;
            exp_sel_high_q <= 1'b0;
            exp_enable_q   <= 1'b0;
        end else if (exp_write) begin
            exp_wp_low_q   <= cpu_data_i[pet_bus_pkg::EXP_WP_LOW];
            exp_wp_high_q  <= cpu_data_i[pet_bus_pkg::EXP_WP_HIGH];
            exp_sel_low_q  <= cpu_data_i[pet_bus_pkg::EXP_SEL_LOW];
            exp_sel_high_q <= cpu_data_i[pet_bus_pkg::EXP_SEL_HIGH];
            exp_enable_q   <= cpu_data_i[pet_bus_pkg::EXP_ENABLE];
        end
    end

    // Region compares
    always_comb begin
        in_vram      = (cpu_addr_i >= pet_bus_pkg::VRAM_BASE)
                       && (cpu_addr_i <= pet_bus_pkg::VRAM_END);
        in_io        = (cpu_addr_i >= pet_bus_pkg::IO_BASE)
                       && (cpu_addr_i <= pet_bus_pkg::IO_END);
        in_rom       = (cpu_addr_i >= pet_bus_pkg::ROM_BASE) && !in_io;
        in_low_bank  = cpu_addr_i[15:14] == 2'b10;      // $8000-$BFFF
        in_high_bank = (cpu_addr_i[15:14] == 2'b11) && !in_io;
        io_window    = cpu_addr_i[15:4];
    end

    always_comb begin
        decode_o     = '0;
        decode_o.a15 = cpu_addr_i[15];

        if (in_io) begin
            // 16 byte windows inside the I/O page
            decode_o.io_en   = 1'b1;
            decode_o.pia1_en = io_window == pet_bus_pkg::PIA1_BASE[15:4];
            decode_o.pia2_en = io_window == pet_bus_pkg::PIA2_BASE[15:4];
            decode_o.via_en  = io_window == pet_bus_pkg::VIA_BASE[15:4];
        end else begin
            decode_o.ram_en      = 1'b1;    // RAM, VRAM and ROM images share the SRAM
            decode_o.is_vram     = in_vram;
            decode_o.is_readonly = in_rom;
        end

        // Expansion banks replace VRAM and ROM in the upper 32 KB
        if (exp_enable_q && in_low_bank) begin
            decode_o.ram_en      = 1'b1;
            decode_o.is_vram     = 1'b0;
            decode_o.is_readonly = exp_wp_low_q;
            decode_o.a15         = exp_sel_low_q;
            decode_o.a16         = 1'b1;
        end else if (exp_enable_q && in_high_bank) begin
            decode_o.ram_en      = 1'b1;
            decode_o.is_vram     = 1'b0;
            decode_o.is_readonly = exp_wp_high_q;
            decode_o.a15         = exp_sel_high_q;
            decode_o.a16         = 1'b1;
        end
    end

endmodule

// File: all.f
pet_bus_pkg.sv
bus_phase_sequencer.sv
address_decoder.sv
bus_steering.sv
pet_bus_top.sv
pet_bus_checker.sv
tb_pet_bus.sv

// File: bus_phase_sequencer.sv
// Free running CPU cycle sequencer, one count per system clock
// Phase levels are registered and so lag the counter state by one clock
// Counter restarts at state 0 after reset, the CPU window starts later
`timescale 1ns/1ps

module bus_phase_sequencer (
    input  logic                    sys_clock_i,
    input  logic                    sys_reset_ni,
    output pet_bus_pkg::bus_phase_t phase_o
);

    logic [pet_bus_pkg::PHASE_WIDTH-1:0] count_q;
    logic                                last_state;
    logic                                be_level;
    logic                                clk_level;
    logic                                strobe_level;

    assign last_state = int'(count_q) == pet_bus_pkg::PHASE_COUNT - 1;

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            count_q <= '0;
        end else if (last_state) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Levels for the current state
    always_comb begin
        be_level     = int'(count_q) >= pet_bus_pkg::PHASE_BE_START;
        clk_level    = int'(count_q) >= pet_bus_pkg::PHASE_CLK_START;
        strobe_level = int'(count_q) == pet_bus_pkg::PHASE_STROBE;
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            phase_o <= '0;      // CPU off the bus, phi2 low
        end else begin
            phase_o.cpu_be      <= be_level;
            phase_o.cpu_clock   <= clk_level;
            phase_o.data_strobe <= strobe_level;
        end
    end

endmodule

// File: bus_steering.sv
// Bus steering between the CPU window and the DMA window, fully combinational
// DMA controls pass straight through while cpu_be is low
// A DMA requester must never assert rd and wr together
`timescale 1ns/1ps

module bus_steering (
    input  pet_bus_pkg::bus_phase_t                phase_i,
    input  pet_bus_pkg::decode_t                   decode_i,
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic                                   cpu_we_i,
    input  pet_bus_pkg::dma_req_t                  dma_i,
    input  pet_bus_pkg::vram_cfg_t                 vram_cfg_i,
    output logic                                   cpu_be_o,
    output logic                                   cpu_clock_o,
    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                                   cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                   cpu_data_oe_o,
    output logic                                   ram_oe_o,
    output logic                                   ram_we_o,
    output logic                                   ram_addr_a10_o,
    output logic                                   ram_addr_a11_o,
    output logic                                   ram_addr_a15_o,
    output logic                                   ram_addr_a16_o,
    output logic                                   io_oe_o,
    output logic                                   pia1_cs_o,
    output logic                                   pia2_cs_o,
    output logic                                   via_cs_o
);

    logic cpu_owns;
    logic a10_mask;
    logic a11_mask;

    assign cpu_owns    = phase_i.cpu_be;
    assign cpu_be_o    = phase_i.cpu_be;
    assign cpu_clock_o = phase_i.cpu_clock;

    // Video RAM wrap masks
    assign a10_mask = !decode_i.is_vram || vram_cfg_i.mask_a10 || vram_cfg_i.col_80;
    assign a11_mask = !decode_i.is_vram || vram_cfg_i.mask_a11;

    // Chip selects only while the CPU owns the bus
    assign io_oe_o   = decode_i.io_en   && cpu_owns;
    assign pia1_cs_o = decode_i.pia1_en && cpu_owns;
    assign pia2_cs_o = decode_i.pia2_en && cpu_owns;
    assign via_cs_o  = decode_i.via_en  && cpu_owns;

    // DMA drives the address and data pins outside the CPU window
    assign cpu_addr_o    = dma_i.addr[pet_bus_pkg::CPU_ADDR_WIDTH-1:0];
    assign cpu_addr_oe_o = !cpu_owns;
    assign cpu_data_o    = dma_i.wdata;
    assign cpu_data_oe_o = !cpu_owns && dma_i.wr;

    always_comb begin
        if (cpu_owns) begin
            ram_oe_o       = decode_i.ram_en && !cpu_we_i;
            ram_we_o       = decode_i.ram_en && !decode_i.is_readonly
                             && cpu_we_i && phase_i.cpu_clock;     // Write only in phi2
            ram_addr_a10_o = cpu_addr_i[10] && a10_mask;
            ram_addr_a11_o = cpu_addr_i[11] && a11_mask;
            ram_addr_a15_o = decode_i.a15;
            ram_addr_a16_o = decode_i.a16;
        end else begin
            ram_oe_o       = dma_i.rd;
            ram_we_o       = dma_i.wr;
            ram_addr_a10_o = dma_i.addr[10];
            ram_addr_a11_o = dma_i.addr[11];
            ram_addr_a15_o = dma_i.addr[15];
            ram_addr_a16_o = dma_i.addr[16];
        end
    end

endmodule

// File: pet_bus_checker.sv
// Bus exclusivity assertions, bound into every pet_bus_top instance
// Checks are off while reset is low
`timescale 1ns/1ps

module pet_bus_checker (
    input logic sys_clock_i,
    input logic sys_reset_ni,
    input logic cpu_be_i,
    input logic io_oe_i,
    input logic ram_oe_i,
    input logic ram_we_i,
    input logic pia1_cs_i,
    input logic pia2_cs_i,
    input logic via_cs_i
);

    logic any_select;

    assign any_select = io_oe_i || pia1_cs_i || pia2_cs_i || via_cs_i;

    io_needs_bus: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        io_oe_i |-> cpu_be_i)
        else $error("io_oe_o active while the CPU does not own the bus");

    io_excludes_ram: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        io_oe_i |-> !(ram_oe_i || ram_we_i))
        else $error("io_oe_o active together with a RAM strobe");

    ram_strobes_apart: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        !($rose(ram_oe_i) && $rose(ram_we_i)))
        else $error("ram_oe_o and ram_we_o rose in the same cycle");

    // DMA window never selects an I/O chip
    no_select_in_dma: assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        !cpu_be_i |-> !any_select)
        else $error("Chip select active while cpu_be_o is low");

endmodule

bind pet_bus_top pet_bus_checker u_checker (
    .sys_clock_i (sys_clock_i),
    .sys_reset_ni(sys_reset_ni),
    .cpu_be_i    (cpu_be_o),
    .io_oe_i     (io_oe_o),
    .ram_oe_i    (ram_oe_o),
    .ram_we_i    (ram_we_o),
    .pia1_cs_i   (pia1_cs_o),
    .pia2_cs_i   (pia2_cs_o),
    .via_cs_i    (via_cs_o)
);

// File: pet_bus_golden.txt
# mode addr we data vcfg dma_addr dma_wdata dma_rd dma_wr, then expected
# ram_oe ram_we a10 a11 a15 a16 io_oe pia1 pia2 via; all hex, mode 1 is DMA, vcfg is {mask_a10,mask_a11,col_80}
# Base memory map, expansion off
0 1234 0 00 6 00000 00 0 0 1 0 0 0 0 0 0 0 0 0
0 0C00 1 55 6 00000 00 0 0 0 1 1 1 0 0 0 0 0 0
0 C400 0 00 6 00000 00 0 0 1 0 1 0 1 0 0 0 0 0
0 A800 1 AA 6 00000 00 0 0 0 0 0 1 1 0 0 0 0 0
0 E810 0 00 6 00000 00 0 0 0 0 0 1 1 0 1 1 0 0
0 E820 0 00 6 00000 00 0 0 0 0 0 1 1 0 1 0 1 0
0 E840 1 12 6 00000 00 0 0 0 0 0 1 1 0 1 0 0 1
0 E880 0 00 6 00000 00 0 0 0 0 0 1 1 0 1 0 0 0
# Video RAM wrap
0 8400 0 00 0 00000 00 0 0 1 0 0 0 1 0 0 0 0 0
0 8800 0 00 0 00000 00 0 0 1 0 0 0 1 0 0 0 0 0
0 8C00 1 20 0 00000 00 0 0 0 1 0 0 1 0 0 0 0 0
0 8400 0 00 1 00000 00 0 0 1 0 1 0 1 0 0 0 0 0
0 8C00 0 00 1 00000 00 0 0 1 0 1 0 1 0 0 0 0 0
0 8C00 0 00 6 00000 00 0 0 1 0 1 1 1 0 0 0 0 0
0 0C00 0 00 0 00000 00 0 0 1 0 1 1 0 0 0 0 0 0
0 9C00 0 00 0 00000 00 0 0 1 0 1 1 1 0 0 0 0 0
# Expansion register, enable with sel_low and wp_high
0 FFF0 1 86 6 00000 00 0 0 0 0 1 1 1 0 0 0 0 0
0 8000 0 00 6 00000 00 0 0 1 0 0 0 1 1 0 0 0 0
0 8000 1 33 6 00000 00 0 0 0 1 0 0 1 1 0 0 0 0
0 C000 0 00 6 00000 00 0 0 1 0 0 0 0 1 0 0 0 0
0 C000 1 44 6 00000 00 0 0 0 0 0 0 0 1 0 0 0 0
0 8C00 0 00 0 00000 00 0 0 1 0 1 1 1 1 0 0 0 0
0 E810 0 00 6 00000 00 0 0 0 0 0 1 1 0 1 1 0 0
0 1234 0 00 6 00000 00 0 0 1 0 0 0 0 0 0 0 0 0
0 FFF0 1 00 6 00000 00 0 0 0 0 1 1 0 1 0 0 0 0
0 C000 0 00 6 00000 00 0 0 1 0 0 0 1 0 0 0 0 0
# DMA window
1 0000 0 00 6 1C4A5 00 1 0 1 0 1 0 1 1 0 0 0 0
1 0000 0 00 6 00800 5A 0 1 0 1 0 1 0 0 0 0 0 0
1 0000 0 00 6 18C00 A5 0 1 0 1 1 1 1 1 0 0 0 0
1 0000 0 00 6 0F400 00 0 0 0 0 1 0 1 0 0 0 0 0
# CPU access after DMA
0 0400 0 00 6 00000 00 0 0 1 0 1 0 0 0 0 0 0 0

// File: pet_bus_pkg.sv
// Widths, PET memory map and the bus struct types shared by the whole bus
// Memory map assumes 32 KB base RAM below $8000 and a 4 KB video window
// ROM images live in external RAM and are protected by decode only
// Expansion banks exist only while EXP_ENABLE is set in the $FFF0 register
package pet_bus_pkg;

    localparam int CPU_ADDR_WIDTH = 16;
    localparam int RAM_ADDR_WIDTH = 17;     // 128 KB external SRAM
    localparam int DATA_WIDTH     = 8;

    // 64 system clocks per 1 MHz CPU cycle
    localparam int PHASE_COUNT     = 64;
    localparam int PHASE_WIDTH     = $clog2(PHASE_COUNT);
    localparam int PHASE_BE_START  = 32;    // CPU owns the bus from here to the end
    localparam int PHASE_CLK_START = 40;    // Phi2 high
    localparam int PHASE_STROBE    = 62;    // CPU data valid

    // PET memory map
    localparam logic [CPU_ADDR_WIDTH-1:0] VRAM_BASE     = 16'h8000;
    localparam logic [CPU_ADDR_WIDTH-1:0] VRAM_END      = 16'h8FFF;
    localparam logic [CPU_ADDR_WIDTH-1:0] ROM_BASE      = 16'h9000;
    localparam logic [CPU_ADDR_WIDTH-1:0] IO_BASE       = 16'hE800;
    localparam logic [CPU_ADDR_WIDTH-1:0] IO_END        = 16'hE8FF;
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA1_BASE     = 16'hE810;
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA2_BASE     = 16'hE820;
    localparam logic [CPU_ADDR_WIDTH-1:0] VIA_BASE      = 16'hE840;
    localparam logic [CPU_ADDR_WIDTH-1:0] EXP_CTRL_ADDR = 16'hFFF0;

    // Bit positions in the expansion control register
    localparam int EXP_WP_LOW   = 0;        // Write protect $8000-$BFFF bank
    localparam int EXP_WP_HIGH  = 1;        // Write protect $C000-$FFFF bank
    localparam int EXP_SEL_LOW  = 2;
    localparam int EXP_SEL_HIGH = 3;
    localparam int EXP_ENABLE   = 7;

    typedef struct packed {
        logic cpu_be;       // CPU owns address and data bus
        logic cpu_clock;    // Phi2
        logic data_strobe;  // One system clock pulse near end of phi2
    } bus_phase_t;

    typedef struct packed {
        logic ram_en;
        logic io_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic is_vram;
        logic is_readonly;
        logic a15;          // Decoded RAM A15
        logic a16;          // Decoded RAM A16, set for expansion banks
    } decode_t;

    typedef struct packed {
        logic [RAM_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     wdata;
        logic                      rd;
        logic                      wr;
    } dma_req_t;

    typedef struct packed {
        logic mask_a10;     // Keep A10 inside VRAM
        logic mask_a11;     // Keep A11 inside VRAM
        logic col_80;       // 80 column mode needs the full 2 KB
    } vram_cfg_t;

endpackage

// File: pet_bus_top.sv
// CPU side system bus of the PET core, 64 MHz system clock
// One CPU cycle every 64 clocks, the first half is the DMA window
// Video RAM mask and 80 column mode are static inputs from outside
`timescale 1ns/1ps

module pet_bus_top (
    input  logic                                   sys_clock_i,
    input  logic                                   sys_reset_ni,
    input  logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                                   cpu_we_i,
    input  pet_bus_pkg::dma_req_t                  dma_i,
    input  pet_bus_pkg::vram_cfg_t                 vram_cfg_i,
    output logic                                   cpu_be_o,
    output logic                                   cpu_clock_o,
    output logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_o,
    output logic                                   cpu_addr_oe_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                   cpu_data_oe_o,
    output logic                                   ram_oe_o,
    output logic                                   ram_we_o,
    output logic                                   ram_addr_a10_o,
    output logic                                   ram_addr_a11_o,
    output logic                                   ram_addr_a15_o,
    output logic                                   ram_addr_a16_o,
    output logic                                   io_oe_o,
    output logic                                   pia1_cs_o,
    output logic                                   pia2_cs_o,
    output logic                                   via_cs_o
);

    pet_bus_pkg::bus_phase_t phase;
    pet_bus_pkg::decode_t    decode;

    bus_phase_sequencer u_sequencer (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .phase_o     (phase)
    );

    address_decoder u_decoder (
        .sys_clock_i  (sys_clock_i),
        .sys_reset_ni (sys_reset_ni),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_we_i     (cpu_we_i),
        .data_strobe_i(phase.data_strobe),  // Expansion register write timing
        .decode_o     (decode)
    );

    bus_steering u_steering (
        .phase_i       (phase),
        .decode_i      (decode),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_we_i      (cpu_we_i),
        .dma_i         (dma_i),
        .vram_cfg_i    (vram_cfg_i),
        .cpu_be_o      (cpu_be_o),
        .cpu_clock_o   (cpu_clock_o),
        .cpu_addr_o    (cpu_addr_o),
        .cpu_addr_oe_o (cpu_addr_oe_o),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .ram_addr_a10_o(ram_addr_a10_o),
        .ram_addr_a11_o(ram_addr_a11_o),
        .ram_addr_a15_o(ram_addr_a15_o),
        .ram_addr_a16_o(ram_addr_a16_o),
        .io_oe_o       (io_oe_o),
        .pia1_cs_o     (pia1_cs_o),
        .pia2_cs_o     (pia2_cs_o),
        .via_cs_o      (via_cs_o)
    );

endmodule

// File: tb_pet_bus.sv
// Golden vector testbench for the PET bus top
// Reads pet_bus_golden.txt from the project root, run from there
// Inputs change on the rising clock edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_pet_bus;

    logic                                   sys_clock;
    logic                                   sys_reset_n;
    logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data;
    logic                                   cpu_we;
    pet_bus_pkg::dma_req_t                  dma;
    pet_bus_pkg::vram_cfg_t                 vram_cfg;

    logic                                   cpu_be;
    logic                                   cpu_clock;
    logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_out;
    logic                                   cpu_addr_oe;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_out;
    logic                                   cpu_data_oe;
    logic                                   ram_oe;
    logic                                   ram_we;
    logic                                   a10;
    logic                                   a11;
    logic                                   a15;
    logic                                   a16;
    logic                                   io_oe;
    logic                                   pia1_cs;
    logic                                   pia2_cs;
    logic                                   via_cs;

    // One golden line
    logic                                   vec_mode;   // 0 CPU access, 1 DMA
    logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] vec_addr;
    logic                                   vec_we;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     vec_data;
    logic [2:0]                             vec_cfg;
    logic [pet_bus_pkg::RAM_ADDR_WIDTH-1:0] vec_dma_addr;
    logic [pet_bus_pkg::DATA_WIDTH-1:0]     vec_dma_wdata;
    logic                                   vec_dma_rd;
    logic                                   vec_dma_wr;
    logic                                   exp_ram_oe;
    logic                                   exp_ram_we;
    logic                                   exp_a10;
    logic                                   exp_a11;
    logic                                   exp_a15;
    logic                                   exp_a16;
    logic                                   exp_io_oe;
    logic                                   exp_pia1;
    logic                                   exp_pia2;
    logic                                   exp_via;
    int   vector_count;

    pet_bus_top u_dut (
        .sys_clock_i   (sys_clock),
        .sys_reset_ni  (sys_reset_n),
        .cpu_addr_i    (cpu_addr),
        .cpu_data_i    (cpu_data),
        .cpu_we_i      (cpu_we),
        .dma_i         (dma),
        .vram_cfg_i    (vram_cfg),
        .cpu_be_o      (cpu_be),
        .cpu_clock_o   (cpu_clock),
        .cpu_addr_o    (cpu_addr_out),
        .cpu_addr_oe_o (cpu_addr_oe),
        .cpu_data_o    (cpu_data_out),
        .cpu_data_oe_o (cpu_data_oe),
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .ram_addr_a10_o(a10),
        .ram_addr_a11_o(a11),
        .ram_addr_a15_o(a15),
        .ram_addr_a16_o(a16),
        .io_oe_o       (io_oe),
        .pia1_cs_o     (pia1_cs),
        .pia2_cs_o     (pia2_cs),
        .via_cs_o      (via_cs)
    );

    initial begin
        sys_clock = 1'b0;
        forever #2 sys_clock = ~sys_clock;      // 250 MHz, only the ratio matters
    end

    task automatic fail_run(input string reason);
        $display("Error: %s (vector %0d)", reason, vector_count);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        assert (got === expected) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (vector %0d)",
                     name, got, expected, vector_count);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_word(name, {15'b0, got}, {15'b0, expected});
    endtask

    // Waits for cpu_be_o or cpu_clock_o to reach a level
    task automatic wait_phase(input logic watch_phi2, input logic level, input string what);
        int   cycles;
        logic seen;
        logic now_level;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge sys_clock);
            now_level = watch_phi2 ? cpu_clock : cpu_be;
            seen      = now_level === level;
            cycles++;
            if (!seen && cycles > 2 * pet_bus_pkg::PHASE_COUNT) begin
                fail_run({"timeout waiting for ", what});
            end
        end
    endtask

    task automatic check_ram_lines();
        check_bit("ram_oe_o", ram_oe, exp_ram_oe);
        check_bit("ram_we_o", ram_we, exp_ram_we);
        check_bit("ram_addr_a10_o", a10, exp_a10);
        check_bit("ram_addr_a11_o", a11, exp_a11);
        check_bit("ram_addr_a15_o", a15, exp_a15);
        check_bit("ram_addr_a16_o", a16, exp_a16);
        check_bit("io_oe_o", io_oe, exp_io_oe);
        check_bit("pia1_cs_o", pia1_cs, exp_pia1);
        check_bit("pia2_cs_o", pia2_cs, exp_pia2);
        check_bit("via_cs_o", via_cs, exp_via);
    endtask

    task automatic apply_vector();
        @(posedge sys_clock);
        cpu_addr <= vec_addr;
        cpu_we   <= vec_we;
        cpu_data <= vec_data;
        vram_cfg <= vec_cfg;
        if (vec_mode) begin
            dma <= '{addr: vec_dma_addr, wdata: vec_dma_wdata, rd: vec_dma_rd, wr: vec_dma_wr};
        end else begin
            dma <= '0;
        end
    endtask

    task automatic run_cpu_vector();
        wait_phase(1'b0, 1'b0, "cpu_be_o low before a CPU access");
        apply_vector();
        wait_phase(1'b1, 1'b1, "cpu_clock_o high");     // Phi2, write strobes valid
        check_bit("cpu_addr_oe_o", cpu_addr_oe, 1'b0);
        check_bit("cpu_data_oe_o", cpu_data_oe, 1'b0);
        check_ram_lines();
        wait_phase(1'b0, 1'b0, "cpu_be_o to fall");     // Expansion write lands here
    endtask

    task automatic run_dma_vector();
        wait_phase(1'b0, 1'b0, "cpu_be_o low before a DMA access");
        apply_vector();
        wait_phase(1'b0, 1'b0, "cpu_be_o low in the DMA window");
        check_bit("cpu_addr_oe_o", cpu_addr_oe, 1'b1);
        check_word("cpu_addr_o", cpu_addr_out, vec_dma_addr[15:0]);
        check_bit("cpu_data_oe_o", cpu_data_oe, vec_dma_wr);
        if (vec_dma_wr) begin
            check_word("cpu_data_o", {8'h00, cpu_data_out}, {8'h00, vec_dma_wdata});
        end
        check_ram_lines();
    endtask

    function automatic logic skip_line(input string text);
        byte first;
        if (text.len() == 0) begin
            return 1'b1;
        end
        first = text.getc(0);
        return (first == "#") || (first == "\n") || (first == "\r");
    endfunction

    initial begin
        int    fd;
        int    fields;
        string line;
        vector_count = 0;
        sys_reset_n  = 1'b0;
        cpu_addr     = '0;
        cpu_data     = '0;
        cpu_we       = 1'b0;
        dma          = '0;
        vram_cfg     = '0;

        repeat (5) @(posedge sys_clock);
        sys_reset_n <= 1'b1;

        // Reset state, CPU off the bus and nothing selected
        @(negedge sys_clock);
        check_bit("cpu_be_o", cpu_be, 1'b0);
        check_bit("cpu_clock_o", cpu_clock, 1'b0);
        check_bit("io_oe_o", io_oe, 1'b0);
        check_bit("pia1_cs_o", pia1_cs, 1'b0);
        check_bit("pia2_cs_o", pia2_cs, 1'b0);
        check_bit("via_cs_o", via_cs, 1'b0);
        check_bit("ram_oe_o", ram_oe, 1'b0);
        check_bit("ram_we_o", ram_we, 1'b0);

        fd = $fopen("pet_bus_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open pet_bus_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (skip_line(line)) begin
                continue;
            end
            vector_count++;
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             vec_mode, vec_addr, vec_we, vec_data, vec_cfg, vec_dma_addr,
                             vec_dma_wdata, vec_dma_rd, vec_dma_wr, exp_ram_oe, exp_ram_we,
                             exp_a10, exp_a11, exp_a15, exp_a16, exp_io_oe, exp_pia1,
                             exp_pia2, exp_via);
            if (fields != 19) begin
                fail_run("malformed line in the golden file");
            end
            if (vec_mode) begin
                run_dma_vector();
            end else begin
                run_cpu_vector();
            end
        end
        $fclose(fd);

        if (vector_count == 0) begin
            $display("Error: golden file holds no vectors");
            $display("=== FAIL ===");
            $fatal(1);
        end else begin
            $display("Ran %0d vectors", vector_count);
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
